/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   // Cache geometry
   localparam int LINE_BYTES     = 16;
   localparam int PADDR_W        = 15;
   localparam int BEAT_W         = 32;
   localparam int BEATS_PER_LINE = 4;
   localparam int DATA_W         = 64;
   localparam int TAG_ID_W       = 4;

   localparam int OFFSET_W    = $clog2(LINE_BYTES);
   localparam int LINE_ADDR_W = PADDR_W - OFFSET_W;

   // Access size in bytes is 1 << code
   typedef enum logic [1:0] {
      SZ_1 = 2'd0,
      SZ_2 = 2'd1,
      SZ_4 = 2'd2,
      SZ_8 = 2'd3
   } size_e;

   typedef logic [LINE_BYTES*8-1:0] line_t;

   typedef struct packed {
      logic [PADDR_W-1:0]  addr;
      size_e               size;
      logic [TAG_ID_W-1:0] tag_id;
   } req_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic [TAG_ID_W-1:0] tag_id;
   } resp_t;

   typedef struct packed {
      logic [LINE_ADDR_W-1:0] line_addr;
   } fill_req_t;

endpackage

`default_nettype wire

/* design/access_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module access_queue #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic
) (
   input  wire           clk,
   input  wire           rst_n_i,
   input  wire           in_valid_i,
   output logic          in_ready_o,
   input  wire payload_t in_data_i,
   output logic          out_valid_o,
   input  wire           out_ready_i,
   output payload_t      out_data_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_d;
   logic             push;
   logic             pop;

   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = mem_q[rd_ptr_q];

   always_comb begin
      case ({push, pop})
         2'b10:   count_d = count_q + 1'b1;
         2'b01:   count_d = count_q - 1'b1;
         default: count_d = count_q;
      endcase
   end

   // Ready is registered from the next count
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         in_ready_o <= 1'b0;
      end else begin
         count_q    <= count_d;
         in_ready_o <= (count_d != CNT_W'(DEPTH));
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= in_data_i;
      end
   end

endmodule

`default_nettype wire

/* design/cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank #(
   parameter int  SETS_PER_BANK = 8,
   localparam int IDX_W         = $clog2(SETS_PER_BANK),
   localparam int TAG_W         = dcache_pkg::LINE_ADDR_W - 1 - IDX_W
) (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  wire [IDX_W-1:0]        index_i,
   input  wire [TAG_W-1:0]        tag_i,
   output logic                   hit_o,
   output dcache_pkg::line_t      line_o,
   input  wire                    fill_i,
   input  wire dcache_pkg::line_t fill_line_i
);

   dcache_pkg::line_t        data_q [SETS_PER_BANK];
   logic [TAG_W-1:0]         tag_q  [SETS_PER_BANK];
   logic [SETS_PER_BANK-1:0] valid_q;

   // Lookup is combinational on the index from the held request
   assign hit_o  = valid_q[index_i] && (tag_q[index_i] == tag_i);
   assign line_o = data_q[index_i];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else if (fill_i) begin
         valid_q[index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_i) begin
         data_q[index_i] <= fill_line_i;
         tag_q[index_i]  <= tag_i;
      end
   end

endmodule

`default_nettype wire

/* design/fill_beat_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module fill_beat_counter (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire                          beat_valid_i,
   input  wire [dcache_pkg::BEAT_W-1:0] beat_i,
   output dcache_pkg::line_t            line_o,
   output logic                         line_done_o
);

   localparam int LINE_W = $bits(dcache_pkg::line_t);
   localparam int HOLD_W = LINE_W - dcache_pkg::BEAT_W;
   localparam int CNT_W  = $clog2(dcache_pkg::BEATS_PER_LINE);

   logic [CNT_W-1:0]  count_q;
   logic [HOLD_W-1:0] shift_q;

   // Last beat goes straight to the bank, earlier ones sit in the shifter
   assign line_o      = {beat_i, shift_q};
   assign line_done_o = beat_valid_i && (count_q == CNT_W'(dcache_pkg::BEATS_PER_LINE - 1));

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (beat_valid_i) begin
         count_q <= count_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_valid_i) begin
         shift_q <= {beat_i, shift_q[HOLD_W-1:dcache_pkg::BEAT_W]};
      end
   end

endmodule

`default_nettype wire

/* design/miss_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module miss_fsm #(
   parameter int  SETS_PER_BANK = 8,
   localparam int IDX_W         = $clog2(SETS_PER_BANK),
   localparam int TAG_W         = dcache_pkg::LINE_ADDR_W - 1 - IDX_W
) (
   input  wire                              clk,
   input  wire                              rst_n_i,
   input  wire                              req_valid_i,
   output logic                             req_ready_o,
   input  wire dcache_pkg::req_t            req_i,
   input  wire                              hit_even_i,
   input  wire                              hit_odd_i,
   input  wire                              line_done_i,
   output logic [IDX_W-1:0]                 even_index_o,
   output logic [IDX_W-1:0]                 odd_index_o,
   output logic [TAG_W-1:0]                 even_tag_o,
   output logic [TAG_W-1:0]                 odd_tag_o,
   output logic                             even_fill_o,
   output logic                             odd_fill_o,
   output logic                             fill_req_valid_o,
   input  wire                              fill_req_ready_i,
   output dcache_pkg::fill_req_t            fill_req_o,
   output logic                             first_is_odd_o,
   output logic [dcache_pkg::OFFSET_W-1:0]  offset_o,
   output dcache_pkg::size_e                size_o,
   output logic                             resp_valid_o,
   input  wire                              resp_ready_i,
   output logic [dcache_pkg::TAG_ID_W-1:0]  resp_tag_id_o
);

   localparam int OFF_W = dcache_pkg::OFFSET_W;
   localparam int LA_W  = dcache_pkg::LINE_ADDR_W;
   localparam int END_W = OFF_W + 1;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      FILL_REQ,
      FILL_WAIT,
      RESPOND
   } state_e;

   state_e           state_q;
   dcache_pkg::req_t req_q;
   logic             fill_odd_q;
   logic [LA_W-1:0]  first_line;
   logic [LA_W-1:0]  next_line;
   logic [LA_W-1:0]  even_line;
   logic [LA_W-1:0]  odd_line;
   logic [END_W-1:0] end_byte;
   logic             crosses;
   logic             miss_even;
   logic             miss_odd;

   assign first_line     = req_q.addr[dcache_pkg::PADDR_W-1:OFF_W];
   assign next_line      = first_line + 1'b1;
   assign first_is_odd_o = first_line[0];
   assign offset_o       = req_q.addr[OFF_W-1:0];
   assign size_o         = req_q.size;
   assign resp_tag_id_o  = req_q.tag_id;

   // Crossing when the last byte lands in the next line
   assign end_byte = {1'b0, offset_o} + (END_W'(1) << req_q.size);
   assign crosses  = end_byte > END_W'(dcache_pkg::LINE_BYTES);

   assign even_line    = first_is_odd_o ? next_line : first_line;
   assign odd_line     = first_is_odd_o ? first_line : next_line;
   assign even_index_o = even_line[IDX_W:1];
   assign odd_index_o  = odd_line[IDX_W:1];
   assign even_tag_o   = even_line[LA_W-1:IDX_W+1];
   assign odd_tag_o    = odd_line[LA_W-1:IDX_W+1];

   assign miss_even = (!first_is_odd_o || crosses) && !hit_even_i;
   assign miss_odd  = (first_is_odd_o || crosses) && !hit_odd_i;

   assign req_ready_o          = (state_q == IDLE);
   assign fill_req_valid_o     = (state_q == FILL_REQ);
   assign fill_req_o.line_addr = fill_odd_q ? odd_line : even_line;
   assign even_fill_o          = (state_q == FILL_WAIT) && line_done_i && !fill_odd_q;
   assign odd_fill_o           = (state_q == FILL_WAIT) && line_done_i && fill_odd_q;
   assign resp_valid_o         = (state_q == RESPOND);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         fill_odd_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (req_valid_i) state_q <= LOOKUP;
            end
            // Even bank is fetched first
            LOOKUP: begin
               if (miss_even) begin
                  fill_odd_q <= 1'b0;
                  state_q    <= FILL_REQ;
               end else if (miss_odd) begin
                  fill_odd_q <= 1'b1;
                  state_q    <= FILL_REQ;
               end else begin
                  state_q <= RESPOND;
               end
            end
            FILL_REQ: begin
               if (fill_req_ready_i) state_q <= FILL_WAIT;
            end
            FILL_WAIT: begin
               if (line_done_i) state_q <= LOOKUP;
            end
            RESPOND: begin
               if (resp_ready_i) state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
   end

endmodule

`default_nettype wire

/* design/output_align.sv */
`timescale 1ns/1ns
`default_nettype none

module output_align (
   input  wire dcache_pkg::line_t          even_line_i,
   input  wire dcache_pkg::line_t          odd_line_i,
   input  wire                             first_is_odd_i,
   input  wire [dcache_pkg::OFFSET_W-1:0]  offset_i,
   input  wire dcache_pkg::size_e          size_i,
   output logic [dcache_pkg::DATA_W-1:0]   data_o
);

   localparam int LINE_W = $bits(dcache_pkg::line_t);

   logic [2*LINE_W-1:0]           pair;
   logic [2*LINE_W-1:0]           shifted;
   logic [dcache_pkg::DATA_W-1:0] mask;

   // First line in the low half so a crossing access runs into the second
   assign pair    = first_is_odd_i ? {even_line_i, odd_line_i} : {odd_line_i, even_line_i};
   assign shifted = pair >> {offset_i, 3'b000};

   always_comb begin
      case (size_i)
         dcache_pkg::SZ_1: mask = 64'h0000_0000_0000_00ff;
         dcache_pkg::SZ_2: mask = 64'h0000_0000_0000_ffff;
         dcache_pkg::SZ_4: mask = 64'h0000_0000_ffff_ffff;
         default:          mask = 64'hffff_ffff_ffff_ffff;
      endcase
      data_o = shifted[dcache_pkg::DATA_W-1:0] & mask;
   end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
   parameter int SETS_PER_BANK = 8,
   parameter int REQ_DEPTH     = 4,
   parameter int RESP_DEPTH    = 4
) (
   input  wire                               clk,
   input  wire                               rst_n_i,
   input  wire                               req_valid_i,
   output logic                              req_ready_o,
   input  wire dcache_pkg::req_t             req_i,
   output logic                              resp_valid_o,
   input  wire                               resp_ready_i,
   output dcache_pkg::resp_t                 resp_o,
   output logic                              fill_req_valid_o,
   input  wire                               fill_req_ready_i,
   output dcache_pkg::fill_req_t             fill_req_o,
   input  wire                               fill_beat_valid_i,
   input  wire [dcache_pkg::BEAT_W-1:0]      fill_beat_i
);

   localparam int IDX_W = $clog2(SETS_PER_BANK);
   localparam int TAG_W = dcache_pkg::LINE_ADDR_W - 1 - IDX_W;

   logic                              fsm_req_valid;
   logic                              fsm_req_ready;
   dcache_pkg::req_t                  fsm_req;
   logic                              fsm_resp_valid;
   logic                              fsm_resp_ready;
   logic [dcache_pkg::DATA_W-1:0]     aligned_data;
   logic [dcache_pkg::TAG_ID_W-1:0]   resp_tag_id;
   logic [IDX_W-1:0]                  even_index;
   logic [IDX_W-1:0]                  odd_index;
   logic [TAG_W-1:0]                  even_tag;
   logic [TAG_W-1:0]                  odd_tag;
   logic                              hit_even;
   logic                              hit_odd;
   logic                              even_fill;
   logic                              odd_fill;
   dcache_pkg::line_t                 even_line;
   dcache_pkg::line_t                 odd_line;
   dcache_pkg::line_t                 fill_line;
   logic                              line_done;
   logic                              first_is_odd;
   logic [dcache_pkg::OFFSET_W-1:0]   offset;
   dcache_pkg::size_e                 size;

   access_queue #(
      .DEPTH     (REQ_DEPTH),
      .payload_t (dcache_pkg::req_t)
   ) req_q (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (req_valid_i),
      .in_ready_o  (req_ready_o),
      .in_data_i   (req_i),
      .out_valid_o (fsm_req_valid),
      .out_ready_i (fsm_req_ready),
      .out_data_o  (fsm_req)
   );

   // Response is the aligned data with the tag id of the held request
   access_queue #(
      .DEPTH     (RESP_DEPTH),
      .payload_t (dcache_pkg::resp_t)
   ) resp_q (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (fsm_resp_valid),
      .in_ready_o  (fsm_resp_ready),
      .in_data_i   ({aligned_data, resp_tag_id}),
      .out_valid_o (resp_valid_o),
      .out_ready_i (resp_ready_i),
      .out_data_o  (resp_o)
   );

   cache_bank #(
      .SETS_PER_BANK (SETS_PER_BANK)
   ) bank_even (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .index_i     (even_index),
      .tag_i       (even_tag),
      .hit_o       (hit_even),
      .line_o      (even_line),
      .fill_i      (even_fill),
      .fill_line_i (fill_line)
   );

   cache_bank #(
      .SETS_PER_BANK (SETS_PER_BANK)
   ) bank_odd (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .index_i     (odd_index),
      .tag_i       (odd_tag),
      .hit_o       (hit_odd),
      .line_o      (odd_line),
      .fill_i      (odd_fill),
      .fill_line_i (fill_line)
   );

   fill_beat_counter fill_beat_counter_inst (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .beat_valid_i (fill_beat_valid_i),
      .beat_i       (fill_beat_i),
      .line_o       (fill_line),
      .line_done_o  (line_done)
   );

   miss_fsm #(
      .SETS_PER_BANK (SETS_PER_BANK)
   ) miss_fsm_inst (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .req_valid_i      (fsm_req_valid),
      .req_ready_o      (fsm_req_ready),
      .req_i            (fsm_req),
      .hit_even_i       (hit_even),
      .hit_odd_i        (hit_odd),
      .line_done_i      (line_done),
      .even_index_o     (even_index),
      .odd_index_o      (odd_index),
      .even_tag_o       (even_tag),
      .odd_tag_o        (odd_tag),
      .even_fill_o      (even_fill),
      .odd_fill_o       (odd_fill),
      .fill_req_valid_o (fill_req_valid_o),
      .fill_req_ready_i (fill_req_ready_i),
      .fill_req_o       (fill_req_o),
      .first_is_odd_o   (first_is_odd),
      .offset_o         (offset),
      .size_o           (size),
      .resp_valid_o     (fsm_resp_valid),
      .resp_ready_i     (fsm_resp_ready),
      .resp_tag_id_o    (resp_tag_id)
   );

   output_align output_align_inst (
      .even_line_i    (even_line),
      .odd_line_i     (odd_line),
      .first_is_odd_i (first_is_odd),
      .offset_i       (offset),
      .size_i         (size),
      .data_o         (aligned_data)
   );

endmodule

`default_nettype wire

/* tb/dcache_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_checker (
   input wire                        clk,
   input wire                        rst_n_i,
   input wire                        resp_valid_i,
   input wire                        resp_ready_i,
   input wire dcache_pkg::resp_t     resp_i,
   input wire                        fill_req_valid_i,
   input wire                        fill_req_ready_i,
   input wire dcache_pkg::fill_req_t fill_req_i,
   input wire                        fill_beat_valid_i
);

   int unsigned assert_fails = 0;

   // Stalled response keeps valid and payload
   resp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
   else begin
      $error("response valid or payload changed while stalled");
      assert_fails++;
   end

   fill_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      fill_req_valid_i && !fill_req_ready_i |=> fill_req_valid_i && $stable(fill_req_i))
   else begin
      $error("fill request valid or line address changed while stalled");
      assert_fails++;
   end

   // Only one miss outstanding
   no_fill_req_in_beats: assert property (@(posedge clk) disable iff (!rst_n_i)
      fill_beat_valid_i |-> !fill_req_valid_i)
   else begin
      $error("fill request raised while fill beats still arrive");
      assert_fails++;
   end

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

   localparam int SETS        = 8;
   localparam int TAG_W       = dcache_pkg::LINE_ADDR_W - 1 - $clog2(SETS);
   localparam int TIMEOUT     = 1000;
   localparam int NUM         = 24;
   localparam int FIRST_BURST = 12;

   typedef struct packed {
      dcache_pkg::req_t req;
      logic [1:0]       fills;
   } entry_t;

   // Address, size, tag id, expected fill count
   localparam entry_t STIM [NUM] = '{
      '{'{15'h0100, dcache_pkg::SZ_1, 4'h1}, 2'd1},
      '{'{15'h0212, dcache_pkg::SZ_2, 4'h2}, 2'd1},
      '{'{15'h0344, dcache_pkg::SZ_4, 4'h3}, 2'd1},
      '{'{15'h0458, dcache_pkg::SZ_8, 4'h4}, 2'd1},
      '{'{15'h0102, dcache_pkg::SZ_2, 4'h5}, 2'd0},
      '{'{15'h045c, dcache_pkg::SZ_4, 4'h6}, 2'd0},
      '{'{15'h052c, dcache_pkg::SZ_8, 4'h7}, 2'd2},
      '{'{15'h063e, dcache_pkg::SZ_4, 4'h8}, 2'd2},
      '{'{15'h1100, dcache_pkg::SZ_4, 4'h9}, 2'd1},
      '{'{15'h0104, dcache_pkg::SZ_4, 4'ha}, 2'd1},
      '{'{15'h1108, dcache_pkg::SZ_2, 4'hb}, 2'd1},
      '{'{15'h1104, dcache_pkg::SZ_1, 4'hc}, 2'd0},
      '{'{15'h0212, dcache_pkg::SZ_8, 4'hd}, 2'd0},
      '{'{15'h0458, dcache_pkg::SZ_1, 4'he}, 2'd0},
      '{'{15'h0344, dcache_pkg::SZ_4, 4'hf}, 2'd1},
      '{'{15'h052c, dcache_pkg::SZ_8, 4'h0}, 2'd1},
      '{'{15'h6ff9, dcache_pkg::SZ_8, 4'h1}, 2'd2},
      '{'{15'h1100, dcache_pkg::SZ_8, 4'h2}, 2'd1},
      '{'{15'h6ffc, dcache_pkg::SZ_4, 4'h3}, 2'd0},
      '{'{15'h0100, dcache_pkg::SZ_2, 4'h4}, 2'd1},
      '{'{15'h0101, dcache_pkg::SZ_1, 4'h5}, 2'd0},
      '{'{15'h6ff0, dcache_pkg::SZ_8, 4'h6}, 2'd0},
      '{'{15'h0218, dcache_pkg::SZ_8, 4'h7}, 2'd0},
      '{'{15'h052a, dcache_pkg::SZ_4, 4'h8}, 2'd0}
   };

   logic                            clk;
   logic                            rst_n_i;
   logic                            req_valid_i;
   logic                            req_ready_o;
   dcache_pkg::req_t                req_i;
   logic                            resp_valid_o;
   logic                            resp_ready_i;
   dcache_pkg::resp_t               resp_o;
   logic                            fill_req_valid_o;
   logic                            fill_req_ready_i;
   dcache_pkg::fill_req_t           fill_req_o;
   logic                            fill_beat_valid_i;
   logic [dcache_pkg::BEAT_W-1:0]   fill_beat_i;

   logic                            stall_en;
   int                              resp_count   = 0;
   int                              fills_seen   = 0;
   int                              resp_errors  = 0;
   int                              fill_errors  = 0;
   int                              other_errors = 0;
   dcache_pkg::resp_t               exp_resp_q [$];
   dcache_pkg::fill_req_t           exp_fill_q [$];
   dcache_pkg::resp_t               resp_head;
   dcache_pkg::fill_req_t           fill_head;
   logic                            mdl_valid [2][SETS];
   logic [TAG_W-1:0]                mdl_tag   [2][SETS];

   dcache_top dcache_top_inst (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .req_valid_i       (req_valid_i),
      .req_ready_o       (req_ready_o),
      .req_i             (req_i),
      .resp_valid_o      (resp_valid_o),
      .resp_ready_i      (resp_ready_i),
      .resp_o            (resp_o),
      .fill_req_valid_o  (fill_req_valid_o),
      .fill_req_ready_i  (fill_req_ready_i),
      .fill_req_o        (fill_req_o),
      .fill_beat_valid_i (fill_beat_valid_i),
      .fill_beat_i       (fill_beat_i)
   );

   bind dcache_top dcache_checker dcache_checker_inst (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .resp_valid_i      (resp_valid_o),
      .resp_ready_i      (resp_ready_i),
      .resp_i            (resp_o),
      .fill_req_valid_i  (fill_req_valid_o),
      .fill_req_ready_i  (fill_req_ready_i),
      .fill_req_i        (fill_req_o),
      .fill_beat_valid_i (fill_beat_valid_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Memory content rule
   function automatic logic [7:0] mem_byte(input logic [dcache_pkg::PADDR_W-1:0] a);
      return a[7:0] ^ 8'(a >> 8);
   endfunction

   function automatic logic [dcache_pkg::BEAT_W-1:0] line_beat(
      input logic [dcache_pkg::LINE_ADDR_W-1:0] line,
      input int                                 b
   );
      logic [dcache_pkg::BEAT_W-1:0] w;
      for (int j = 0; j < 4; j++) begin
         w[8*j +: 8] = mem_byte({line, 4'b0000} + dcache_pkg::PADDR_W'(4*b + j));
      end
      return w;
   endfunction

   function automatic logic [dcache_pkg::DATA_W-1:0] expected_data(input dcache_pkg::req_t r);
      logic [dcache_pkg::DATA_W-1:0] d;
      int                            n;
      d = '0;
      n = 1 << int'(r.size);
      for (int k = 0; k < n; k++) begin
         d[8*k +: 8] = mem_byte(r.addr + dcache_pkg::PADDR_W'(k));
      end
      return d;
   endfunction

   // Both banks direct mapped with the even line fetched first
   task automatic predict_fills(input dcache_pkg::req_t r);
      logic [dcache_pkg::LINE_ADDR_W-1:0] first;
      logic [dcache_pkg::LINE_ADDR_W-1:0] lines [2];
      dcache_pkg::fill_req_t              f;
      int                                 n_lines;
      logic                               bank;
      logic [$clog2(SETS)-1:0]            idx;
      first   = r.addr[dcache_pkg::PADDR_W-1:4];
      n_lines = (int'(r.addr[3:0]) + (1 << int'(r.size)) > dcache_pkg::LINE_BYTES) ? 2 : 1;
      lines[0] = first;
      lines[1] = first + 1'b1;
      if (n_lines == 2 && first[0]) begin
         lines[0] = first + 1'b1;
         lines[1] = first;
      end
      for (int i = 0; i < n_lines; i++) begin
         bank = lines[i][0];
         idx  = lines[i][3:1];
         if (!(mdl_valid[bank][idx] && mdl_tag[bank][idx] == lines[i][10:4])) begin
            mdl_valid[bank][idx] = 1'b1;
            mdl_tag[bank][idx]   = lines[i][10:4];
            f.line_addr          = lines[i];
            exp_fill_q.push_back(f);
         end
      end
   endtask

   task automatic check_resp(input dcache_pkg::resp_t got, input dcache_pkg::resp_t exp);
      if (got !== exp) begin
         resp_errors++;
         $display("[FAIL] %0t ns: response tag %h data %h, expected tag %h data %h",
                  $time, got.tag_id, got.data, exp.tag_id, exp.data);
      end
   endtask

   task automatic check_fill_req(input dcache_pkg::fill_req_t got,
                                 input dcache_pkg::fill_req_t exp);
      if (got !== exp) begin
         fill_errors++;
         $display("[FAIL] %0t ns: fill request line %h, expected line %h",
                  $time, got.line_addr, exp.line_addr);
      end
   endtask

   task automatic expect_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         other_errors++;
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic expect_count(input int got, input int exp, input string what);
      if (got != exp) begin
         other_errors++;
         $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic print_counts();
      $display("Errors: response %0d, fill %0d, other %0d, assertion %0d",
               resp_errors, fill_errors, other_errors,
               dcache_top_inst.dcache_checker_inst.assert_fails);
   endtask

   task automatic hang(input string what);
      $display("Timeout: %s", what);
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   // Called on a rising edge and returns on the transfer edge
   task automatic push_req(input dcache_pkg::req_t r);
      int waited;
      req_valid_i <= 1'b1;
      req_i       <= r;
      waited = 0;
      @(negedge clk);
      while (!req_ready_o && waited < TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (!req_ready_o) begin
         hang("request queue never accepted a request");
      end
      @(posedge clk);
   endtask

   task automatic wait_responses(input int n);
      int waited;
      waited = 0;
      while (resp_count < n && waited < TIMEOUT) begin
         waited++;
         @(posedge clk);
      end
      if (resp_count < n) begin
         hang("expected responses never arrived");
      end
   endtask

   task automatic apply_entry(input int i);
      dcache_pkg::resp_t e;
      predict_fills(STIM[i].req);
      e.data   = expected_data(STIM[i].req);
      e.tag_id = STIM[i].req.tag_id;
      exp_resp_q.push_back(e);
      push_req(STIM[i].req);
   endtask

   task automatic serve_fill(input logic [dcache_pkg::LINE_ADDR_W-1:0] line);
      int delay;
      delay = int'($urandom % 4);
      @(posedge clk);
      repeat (delay) @(posedge clk);
      for (int b = 0; b < dcache_pkg::BEATS_PER_LINE; b++) begin
         fill_beat_valid_i <= 1'b1;
         fill_beat_i       <= line_beat(line, b);
         @(posedge clk);
      end
      fill_beat_valid_i <= 1'b0;
   endtask

   // Response stalls only in the burst phase
   initial begin
      resp_ready_i     = 1'b0;
      fill_req_ready_i = 1'b0;
      forever begin
         @(posedge clk);
         if (!rst_n_i) begin
            resp_ready_i     <= 1'b0;
            fill_req_ready_i <= 1'b0;
         end else begin
            resp_ready_i     <= stall_en ? ($urandom % 4 == 0) : 1'b1;
            fill_req_ready_i <= ($urandom % 3 != 0);
         end
      end
   end

   // Memory model answers the line it was asked for
   initial begin
      fill_beat_valid_i = 1'b0;
      fill_beat_i       = '0;
      forever begin
         @(negedge clk);
         if (rst_n_i && fill_req_valid_o && fill_req_ready_i) begin
            if (exp_fill_q.size() == 0) begin
               fill_errors++;
               $display("Unexpected fill request for line %h", fill_req_o.line_addr);
            end else begin
               fill_head = exp_fill_q.pop_front();
               check_fill_req(fill_req_o, fill_head);
            end
            fills_seen++;
            serve_fill(fill_req_o.line_addr);
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n_i && resp_valid_o && resp_ready_i) begin
         if (exp_resp_q.size() == 0) begin
            resp_errors++;
            $display("Unexpected response with tag %h", resp_o.tag_id);
         end else begin
            resp_head = exp_resp_q.pop_front();
            check_resp(resp_o, resp_head);
         end
         resp_count++;
      end
   end

   initial begin
      int fills_before;
      int total_fills;
      int total_errors;
      void'($urandom(32'h94f4));
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      stall_en    = 1'b0;
      total_fills = 0;
      foreach (mdl_valid[b, s]) begin
         mdl_valid[b][s] = 1'b0;
         mdl_tag[b][s]   = '0;
      end
      repeat (16) @(posedge clk);
      rst_n_i <= 1'b1;
      @(negedge clk);
      expect_flag(resp_valid_o, 1'b0, "resp_valid_o after reset");
      expect_flag(fill_req_valid_o, 1'b0, "fill_req_valid_o after reset");
      expect_flag(req_ready_o, 1'b0, "req_ready_o after reset");
      @(posedge clk);

      // One request at a time with fills counted per request
      for (int i = 0; i < FIRST_BURST; i++) begin
         fills_before = fills_seen;
         apply_entry(i);
         req_valid_i <= 1'b0;
         wait_responses(i + 1);
         expect_count(fills_seen - fills_before, STIM[i].fills, "fill requests of entry");
      end

      // Back-to-back burst under response stalls
      stall_en <= 1'b1;
      for (int i = FIRST_BURST; i < NUM; i++) begin
         apply_entry(i);
      end
      req_valid_i <= 1'b0;
      wait_responses(NUM);

      foreach (STIM[i]) total_fills += STIM[i].fills;
      expect_count(fills_seen, total_fills, "total fill requests");
      @(negedge clk);
      expect_flag(resp_valid_o, 1'b0, "resp_valid_o after the last response");
      if (exp_fill_q.size() != 0) begin
         other_errors++;
         $display("Predicted fill requests were never issued");
      end

      total_errors = resp_errors + fill_errors + other_errors +
                     int'(dcache_top_inst.dcache_checker_inst.assert_fails);
      print_counts();
      if (total_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dcache_top.f */
design/dcache_pkg.sv
design/access_queue.sv
design/cache_bank.sv
design/fill_beat_counter.sv
design/miss_fsm.sv
design/output_align.sv
design/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv
